/* source/spi_pkg.sv */
package spi_pkg;

	//////////////////////////////
	// Frame and clock sizing
	//////////////////////////////

	// Bits per transfer
	localparam int WORD_WIDTH = 32;

	// Bit counter also times the CS hold, must reach WORD_WIDTH
	localparam int BIT_CNT_WIDTH = 6;

	// 50 MHz / (2 * 2) gives SCK at 12.5 MHz
	localparam int SCK_HALF_CYCLES = 2;
	localparam int SCK_CNT_WIDTH = $clog2(SCK_HALF_CYCLES + 1);

	// Last SCK low half plus one half period of CS hold
	localparam int HOLD_CYCLES = 2 * SCK_HALF_CYCLES;

	typedef logic [WORD_WIDTH-1:0] spi_word_t;
	typedef logic [BIT_CNT_WIDTH-1:0] bit_cnt_t;
	typedef logic [SCK_CNT_WIDTH-1:0] sck_cnt_t;

	//////////////////////////////
	// Host and pin bundles
	//////////////////////////////

	typedef struct packed {
		spi_word_t tx_data;
	} spi_req_t;

	typedef struct packed {
		spi_word_t rx_data;
	} spi_rsp_t;

	typedef struct packed {
		logic sck;
		logic cs_n;
		logic mosi;
	} spi_pins_t;

	//////////////////////////////
	// Control encodings
	//////////////////////////////

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_SETUP = 3'd1,
		ST_SHIFT = 3'd2,
		ST_HOLD  = 3'd3,
		ST_ACK   = 3'd4
	} ctrl_state_t;

	// Commands from control to the shift datapath
	typedef enum logic [2:0] {
		CMD_NONE   = 3'd0,
		CMD_LOAD   = 3'd1,
		CMD_DRIVE  = 3'd2,
		CMD_SAMPLE = 3'd3,
		CMD_CLEAR  = 3'd4
	} shift_cmd_t;

endpackage

/* source/spi_sck_gen.sv */
`timescale 1ns/10ps

module spi_sck_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic sck_en,
	output logic sck,
	output logic sck_rise,
	output logic sck_fall
);

	spi_pkg::sck_cnt_t half_cnt;
	logic half_done;

	// Last cycle of the current half period
	assign half_done = (half_cnt == spi_pkg::sck_cnt_t'(spi_pkg::SCK_HALF_CYCLES - 1));

	//////////////////////////////
	// Half period counter
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST || !sck_en) begin
			half_cnt <= '0;
		end else if (half_done) begin
			half_cnt <= '0;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// SCK toggle flop
	//////////////////////////////

	// Idles low while disabled, so every frame opens with a low half
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !sck_en) begin
			sck <= 1'b0;
		end else if (half_done) begin
			sck <= ~sck;
		end
	end

	// Strobes lead the SCK edge by one cycle
	assign sck_rise = sck_en && half_done && !sck;
	assign sck_fall = sck_en && half_done && sck;

endmodule

/* source/spi_shifter.sv */
`timescale 1ns/10ps

module spi_shifter (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	input  spi_pkg::shift_cmd_t  cmd,
	input  spi_pkg::spi_word_t   load_word,
	input  logic                 miso,
	output logic                 mosi,
	output spi_pkg::spi_word_t   rx_word
);

	spi_pkg::spi_word_t tx_reg;
	spi_pkg::spi_word_t rx_reg;

	assign rx_word = rx_reg;

	//////////////////////////////
	// Transmit path
	//////////////////////////////

	// Remaining bits wait left aligned behind the MOSI flop
	always_ff @(posedge CLK50MHZ) begin
		case (cmd)
			spi_pkg::CMD_LOAD: begin
				tx_reg <= {load_word[spi_pkg::WORD_WIDTH-2:0], 1'b0};
			end
			spi_pkg::CMD_DRIVE: begin
				tx_reg <= {tx_reg[spi_pkg::WORD_WIDTH-2:0], 1'b0};
			end
			default: begin
				tx_reg <= tx_reg;
			end
		endcase
	end

	// MOSI flop, MSB goes out first
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			mosi <= 1'b0;
		end else begin
			case (cmd)
				spi_pkg::CMD_LOAD:  mosi <= load_word[spi_pkg::WORD_WIDTH-1];
				spi_pkg::CMD_DRIVE: mosi <= tx_reg[spi_pkg::WORD_WIDTH-1];
				spi_pkg::CMD_CLEAR: mosi <= 1'b0;
				default:            mosi <= mosi;
			endcase
		end
	end

	//////////////////////////////
	// Receive path
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (cmd == spi_pkg::CMD_LOAD) begin
			rx_reg <= '0;
		end else if (cmd == spi_pkg::CMD_SAMPLE) begin
			rx_reg <= {rx_reg[spi_pkg::WORD_WIDTH-2:0], miso};   // new bit into LSB
		end
	end

endmodule

/* source/spi_ctrl.sv */
`timescale 1ns/10ps

module spi_ctrl (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	input  logic                 req,
	input  spi_pkg::spi_word_t   tx_data,
	output logic                 ack,
	output logic                 sck_en,
	input  logic                 sck_rise,
	input  logic                 sck_fall,
	output spi_pkg::shift_cmd_t  cmd,
	output spi_pkg::spi_word_t   load_word,
	output logic                 cs_n
);

	spi_pkg::ctrl_state_t state;
	spi_pkg::bit_cnt_t bit_cnt;
	logic last_bit;
	logic hold_done;

	// Shifter captures the host word with CMD_LOAD
	assign load_word = tx_data;

	assign last_bit = (bit_cnt == spi_pkg::bit_cnt_t'(spi_pkg::WORD_WIDTH - 1));
	assign hold_done = (bit_cnt == spi_pkg::bit_cnt_t'(spi_pkg::HOLD_CYCLES - 1));

	// SCK runs from the setup half through the last falling edge
	assign sck_en = (state == spi_pkg::ST_SETUP) || (state == spi_pkg::ST_SHIFT);

	//////////////////////////////
	// Transfer FSM
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state   <= spi_pkg::ST_IDLE;
			bit_cnt <= '0;
			cs_n    <= 1'b1;
			ack     <= 1'b0;
		end else begin
			case (state)
				spi_pkg::ST_IDLE: begin
					bit_cnt <= '0;
					if (req) begin
						cs_n  <= 1'b0;
						state <= spi_pkg::ST_SETUP;
					end
				end
				// First rise strobe ends the setup half period
				spi_pkg::ST_SETUP: begin
					if (sck_rise) begin
						state <= spi_pkg::ST_SHIFT;
					end
				end
				// One count per falling edge
				spi_pkg::ST_SHIFT: begin
					if (sck_fall) begin
						if (last_bit) begin
							bit_cnt <= '0;
							state   <= spi_pkg::ST_HOLD;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				// Counter reused to time the CS hold
				spi_pkg::ST_HOLD: begin
					if (hold_done) begin
						cs_n  <= 1'b1;
						state <= spi_pkg::ST_ACK;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				spi_pkg::ST_ACK: begin
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack   <= 1'b0;
						state <= spi_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= spi_pkg::ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Shifter command decode
	//////////////////////////////

	always_comb begin
		cmd = spi_pkg::CMD_NONE;
		case (state)
			spi_pkg::ST_IDLE: begin
				if (req) cmd = spi_pkg::CMD_LOAD;
			end
			spi_pkg::ST_SETUP, spi_pkg::ST_SHIFT: begin
				if (sck_rise) begin
					cmd = spi_pkg::CMD_SAMPLE;
				end else if (sck_fall && !last_bit) begin
					cmd = spi_pkg::CMD_DRIVE;
				end
			end
			spi_pkg::ST_HOLD: begin
				if (hold_done) cmd = spi_pkg::CMD_CLEAR;
			end
			default: begin
				cmd = spi_pkg::CMD_NONE;
			end
		endcase
	end

endmodule

/* source/spi_master_top.sv */
`timescale 1ns/10ps

module spi_master_top (
	input  logic                CLK50MHZ,
	input  logic                RST,
	input  logic                req,
	input  spi_pkg::spi_req_t   req_data,
	output logic                ack,
	output spi_pkg::spi_rsp_t   rsp_data,
	output spi_pkg::spi_pins_t  pins,
	input  logic                miso
);

	logic sck_en;
	logic sck;
	logic sck_rise;
	logic sck_fall;
	logic cs_n;
	logic mosi;
	spi_pkg::shift_cmd_t cmd;
	spi_pkg::spi_word_t load_word;
	spi_pkg::spi_word_t rx_word;

	spi_ctrl i_ctrl (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.req       (req),
		.tx_data   (req_data.tx_data),
		.ack       (ack),
		.sck_en    (sck_en),
		.sck_rise  (sck_rise),
		.sck_fall  (sck_fall),
		.cmd       (cmd),
		.load_word (load_word),
		.cs_n      (cs_n)
	);

	spi_sck_gen i_sck_gen (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.sck_en   (sck_en),
		.sck      (sck),
		.sck_rise (sck_rise),
		.sck_fall (sck_fall)
	);

	spi_shifter i_shifter (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.cmd       (cmd),
		.load_word (load_word),
		.miso      (miso),
		.mosi      (mosi),
		.rx_word   (rx_word)
	);

	// Pin bundle and host response
	assign pins.sck  = sck;
	assign pins.cs_n = cs_n;
	assign pins.mosi = mosi;
	assign rsp_data.rx_data = rx_word;

endmodule

/* tb/spi_slave_model.sv */
`timescale 1ns/10ps

module spi_slave_model (
	input  spi_pkg::spi_pins_t pins,
	input  spi_pkg::spi_word_t reply_word,
	output logic               miso,
	output spi_pkg::spi_word_t captured,
	output int                 rise_cnt,
	output int                 frame_cnt
);

	spi_pkg::spi_word_t tx_sh = '0;
	int edge_cnt = 0;
	logic sck_prev = 1'b0;
	logic cs_prev = 1'b1;
	logic sck;
	logic cs_n;

	assign sck = pins.sck;
	assign cs_n = pins.cs_n;
	assign miso = tx_sh[spi_pkg::WORD_WIDTH-1];

	initial begin
		captured = '0;
		rise_cnt = 0;
		frame_cnt = 0;
	end

	// Mode 0 slave, MISO moves after falling SCK, MOSI taken on rising SCK
	always @(posedge sck or negedge sck or posedge cs_n or negedge cs_n) begin
		if (cs_n && !cs_prev) begin
			rise_cnt = edge_cnt;
			frame_cnt = frame_cnt + 1;
		end else if (!cs_n && cs_prev) begin
			tx_sh = reply_word;
			captured = '0;
			edge_cnt = 0;
		end else if (!cs_n && sck && !sck_prev) begin
			captured = {captured[spi_pkg::WORD_WIDTH-2:0], pins.mosi};
			edge_cnt = edge_cnt + 1;
		end else if (!cs_n && !sck && sck_prev) begin
			tx_sh = {tx_sh[spi_pkg::WORD_WIDTH-2:0], 1'b0};
		end
		sck_prev = sck;
		cs_prev = cs_n;
	end

endmodule

/* tb/spi_master_assert.sv */
`timescale 1ns/10ps

module spi_master_assert (
	input logic               CLK50MHZ,
	input logic               RST,
	input logic               req,
	input logic               ack,
	input spi_pkg::spi_pins_t pins
);

	int unsigned sck_err = 0;
	int unsigned ack_rise_err = 0;
	int unsigned ack_hold_err = 0;
	int unsigned mosi_err = 0;
	int unsigned fail_cnt;

	assign fail_cnt = sck_err + ack_rise_err + ack_hold_err + mosi_err;

	//////////////////////////////
	// Pin protocol
	//////////////////////////////

	sck_idle_low: assert property (@(posedge CLK50MHZ) disable iff (RST)
		pins.cs_n |-> !pins.sck)
		else begin
			sck_err++;
			$error("SCK high while CS is inactive");
		end

	// Slave samples MOSI during the high half
	mosi_stable: assert property (@(posedge CLK50MHZ) disable iff (RST)
		pins.sck |-> $stable(pins.mosi))
		else begin
			mosi_err++;
			$error("MOSI changed while SCK was high");
		end

	//////////////////////////////
	// Host handshake
	//////////////////////////////

	ack_after_frame: assert property (@(posedge CLK50MHZ) disable iff (RST)
		$rose(ack) |-> pins.cs_n)
		else begin
			ack_rise_err++;
			$error("ack rose during an open frame");
		end

	ack_held: assert property (@(posedge CLK50MHZ) disable iff (RST)
		(ack && req) |=> ack)
		else begin
			ack_hold_err++;
			$error("ack dropped while req was still high");
		end

endmodule

bind spi_master_top spi_master_assert i_assert (
	.CLK50MHZ (CLK50MHZ),
	.RST      (RST),
	.req      (req),
	.ack      (ack),
	.pins     (pins)
);

/* tb/tb_spi_master.sv */
`timescale 1ns/10ps

module tb_spi_master;

	localparam int ACK_TIMEOUT = 1000;
	localparam int RANDOM_CASES = 8;

	logic CLK50MHZ = 1'b0;
	logic RST;
	logic req;
	spi_pkg::spi_req_t req_data;
	logic ack;
	spi_pkg::spi_rsp_t rsp_data;
	spi_pkg::spi_pins_t pins;
	logic miso;
	spi_pkg::spi_word_t reply_word;
	spi_pkg::spi_word_t captured;
	int rise_cnt;
	int frame_cnt;
	int frames_sent;

	spi_master_top i_dut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.req      (req),
		.req_data (req_data),
		.ack      (ack),
		.rsp_data (rsp_data),
		.pins     (pins),
		.miso     (miso)
	);

	spi_slave_model i_slave (
		.pins       (pins),
		.reply_word (reply_word),
		.miso       (miso),
		.captured   (captured),
		.rise_cnt   (rise_cnt),
		.frame_cnt  (frame_cnt)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			abort_run();
		end
	endtask

	// Polls on falling edges until ack reaches the given level
	task automatic wait_ack(input logic level, input string name);
		int cycles;
		cycles = 0;
		while (ack !== level) begin
			@(negedge CLK50MHZ);
			cycles++;
			if (cycles > ACK_TIMEOUT) begin
				$display("Timeout: ack never went to %0b in case %s", level, name);
				abort_run();
			end
		end
	endtask

	task automatic check_idle_pins(input string name);
		check_value({name, " cs_n"}, 32'd1, 32'(pins.cs_n));
		check_value({name, " sck"}, 32'd0, 32'(pins.sck));
		check_value({name, " mosi"}, 32'd0, 32'(pins.mosi));
		check_value({name, " ack"}, 32'd0, 32'(ack));
	endtask

	task automatic quiet_gap(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge CLK50MHZ);
			check_idle_pins(name);
		end
	endtask

	// Called on a falling edge, returns on the falling edge where ack is low
	task automatic run_transfer(input string name, input spi_pkg::spi_word_t tx,
			input spi_pkg::spi_word_t reply, input int hold_cycles);
		reply_word = reply;
		req_data.tx_data = tx;
		req = 1'b1;
		frames_sent++;
		wait_ack(1'b1, name);
		check_value({name, " rx_data"}, reply, rsp_data.rx_data);
		check_value({name, " slave mosi word"}, tx, captured);
		check_value({name, " sck rises"}, spi_pkg::WORD_WIDTH, rise_cnt);
		check_value({name, " frame count"}, frames_sent, frame_cnt);
		repeat (hold_cycles) begin
			@(negedge CLK50MHZ);
			check_value({name, " ack held"}, 32'd1, 32'(ack));
		end
		req = 1'b0;
		wait_ack(1'b0, name);
	endtask

	always @(negedge CLK50MHZ) begin
		if (i_dut.i_assert.fail_cnt != 0) begin
			$display("A protocol assertion on the DUT pins or handshake failed");
			abort_run();
		end
	end

	initial begin
		int fd;
		string line;
		string name;
		spi_pkg::spi_word_t tx;
		spi_pkg::spi_word_t reply;
		RST = 1'b1;
		req = 1'b0;
		req_data = '0;
		reply_word = '0;
		frames_sent = 0;
		void'($urandom(19900));
		repeat (10) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RST = 1'b0;
		quiet_gap("after reset", 4);

		fd = $fopen("tb/spi_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file tb/spi_cases.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0) begin
				// Comment lines do not parse to three fields
				if ($sscanf(line, "%s %h %h", name, tx, reply) == 3) begin
					run_transfer(name, tx, reply, 5);
					quiet_gap({name, " idle"}, 3);
				end
			end
		end
		$fclose(fd);

		// Back to back, next req right after ack drops
		for (int i = 0; i < RANDOM_CASES; i++) begin
			tx = $urandom();
			reply = $urandom();
			run_transfer($sformatf("random_%0d", i), tx, reply, 0);
		end
		quiet_gap("end of run", 3);

		if (i_dut.i_assert.fail_cnt == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("A protocol assertion failed during the run");
			abort_run();
		end
	end

endmodule

/* spi_master.f */
source/spi_pkg.sv
source/spi_sck_gen.sv
source/spi_shifter.sv
source/spi_ctrl.sv
source/spi_master_top.sv
tb/spi_slave_model.sv
tb/spi_master_assert.sv
tb/tb_spi_master.sv

/* Makefile */
# Verilator build and run for the SPI master

VERILATOR ?= verilator
TOP       ?= tb_spi_master
RTL_TOP   ?= spi_master_top
FILELIST  ?= spi_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
RTL_FILES := $(filter source/%,$(SOURCES))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/spi_cases.txt */
# name  tx_word  reply_word
# hex words, MSB goes out first on both lines
zeros         00000000  00000000
ones          ffffffff  ffffffff
msb_lsb       80000001  00000080
low_byte_bit  00000080  80000001
single_msb    80000000  00000001
single_lsb    00000001  80000000
alternating   a5a5a5a5  5a5a5a5a
counting      01234567  89abcdef
reversed      fedcba98  76543210
mixed         c0ffee00  0badf00d
